//--- design/palette_lut.sv
// 256x4 colour lookup, written from the programming port
// Read side only moves on the pixel enable

`timescale 1ns/1ps

module palette_lut
    import scroll_pkg::*;
(
    input  logic      clk,
    input  logic      pxl_cen,
    // Programming port
    input  pal_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  logic      we,
    // Pixel lookup
    input  pal_addr_t rd_addr,
    output pixel_t    q
);

    pixel_t table_mem [0:255];

    always_ff @(posedge clk) begin
        if (we) table_mem[wr_addr] <= wr_data; // Any edge while we is high
    end

    // Registered colour index, one pixel behind rd_addr
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            q <= table_mem[rd_addr];
        end
    end

endmodule

//--- design/scroll_layer.sv
// Background scroll layer top with its own video timing
// Bank 0 holds attributes, bank 1 holds codes; both ports share clk
// Priority output and palette bypass are not provided

`timescale 1ns/1ps

module scroll_layer
    import scroll_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flip,
    // CPU
    input  cpu_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    input  logic      cpu_rnw,
    input  logic      vram_cs,
    input  logic      vscr_cs,
    output byte_t     vram_dout,
    output byte_t     vscr_dout,
    // Palette programming
    input  pal_addr_t prog_addr,
    input  pixel_t    prog_data,
    input  logic      prog_en,
    // Tile ROM
    output rom_addr_t rom_addr,
    input  rom_word_t rom_data,
    // Video
    output logic      pxl_cen,
    output hcount_t   hdump,
    output vcount_t   vdump,
    output logic      lhbl,
    output logic      lvbl,
    output pixel_t    pxl
);

    logic       vram_we;
    logic       attr_we;
    logic       code_we;
    logic       scr_we;
    byte_t      attr_q;   // CPU read, bank 0
    byte_t      code_q;   // CPU read, bank 1
    byte_t      attr;
    byte_t      code;
    vcount_t    vscr;
    vram_addr_t vid_addr;
    pal_addr_t  pal_addr;

    // Bank decode
    assign vram_we   = vram_cs & ~cpu_rnw;
    assign attr_we   = vram_we & ~cpu_addr[BANK_SEL_BIT];
    assign code_we   = vram_we &  cpu_addr[BANK_SEL_BIT];
    assign scr_we    = vscr_cs & ~cpu_rnw;
    assign vram_dout = cpu_addr[BANK_SEL_BIT] ? code_q : attr_q;
    assign vscr_dout = vscr;

    video_timing i_video_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .lhbl(lhbl), .lvbl(lvbl)
    );

    scroll_tile_engine i_scroll_tile_engine (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .flip(flip),
        .scr_we(scr_we), .scr_din(cpu_dout), .vscr(vscr),
        .vid_addr(vid_addr), .attr(attr), .code(code),
        .rom_addr(rom_addr), .rom_data(rom_data), .pal_addr(pal_addr)
    );

    video_ram i_attr_ram (
        .clk(clk), .cpu_addr(cpu_addr[9:0]), .cpu_din(cpu_dout), .cpu_we(attr_we),
        .cpu_q(attr_q), .vid_addr(vid_addr), .vid_q(attr)
    );

    video_ram i_code_ram (
        .clk(clk), .cpu_addr(cpu_addr[9:0]), .cpu_din(cpu_dout), .cpu_we(code_we),
        .cpu_q(code_q), .vid_addr(vid_addr), .vid_q(code)
    );

    palette_lut i_palette_lut (
        .clk(clk), .pxl_cen(pxl_cen),
        .wr_addr(prog_addr), .wr_data(prog_data), .we(prog_en),
        .rd_addr(pal_addr), .q(pxl)
    );

endmodule

//--- design/scroll_pkg.sv
// Widths and geometry for one Kicker-style background tile layer
// Only the unpacked ROM bit order of this layout is covered
// Geometry values assume a 2-clock pixel and a 384x264 raster

package scroll_pkg;

    // Plain vector types
    typedef logic [7:0]  byte_t;      // CPU data byte
    typedef logic [9:0]  vram_addr_t; // 5b tile row + 5b tile column
    typedef logic [10:0] cpu_addr_t;  // Bit 10 picks the bank
    typedef logic [8:0]  hcount_t;    // Horizontal position
    typedef logic [7:0]  vcount_t;    // Vertical position
    typedef logic [12:0] rom_addr_t;  // Code high, code, row
    typedef logic [31:0] rom_word_t;  // 8 pixels of 4 bits
    typedef logic [3:0]  pixel_t;     // Pixel or colour index
    typedef logic [7:0]  pal_addr_t;  // Palette bits + pixel

    // CPU bank decode
    localparam int unsigned BANK_SEL_BIT = 10;

    // Fixed score area on the left of the screen
    localparam int unsigned SCORE_COLS = 32;

    // Columns blanked when the screen is flipped
    localparam int unsigned FLIP_BLANK_COLS = 16;

    // Raster
    localparam int unsigned H_TOTAL  = 384;
    localparam int unsigned H_ACTIVE = 256;
    localparam int unsigned V_TOTAL  = 264;
    localparam int unsigned V_ACTIVE = 224;
    localparam int unsigned CEN_DIV  = 2; // clk cycles per pixel

    // Attribute byte fields
    localparam int unsigned ATTR_VFLIP    = 5;
    localparam int unsigned ATTR_HFLIP    = 4;
    localparam int unsigned ATTR_CODE_LSB = 6; // Bits 7:6
    localparam int unsigned ATTR_PAL_LSB  = 0; // Bits 3:0

endpackage

//--- design/scroll_tile_engine.sv
// Scroll register, tile fetch and pixel shifter for the Kicker layout
// rom_data must be valid within 4 pixels of the rom_addr update
// Only the unpacked ROM bit order is decoded

`timescale 1ns/1ps

module scroll_tile_engine
    import scroll_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    // Raster position
    input  hcount_t    hdump,
    input  vcount_t    vdump,
    input  logic       flip,
    // Scroll register write
    input  logic       scr_we,
    input  byte_t      scr_din,
    output vcount_t    vscr,
    // Tile map
    output vram_addr_t vid_addr,
    input  byte_t      attr,
    input  byte_t      code,
    // Tile ROM
    output rom_addr_t  rom_addr,
    input  rom_word_t  rom_data,
    // Palette
    output pal_addr_t  pal_addr
);

    byte_t      vpos;      // Scroll value from the CPU
    logic [7:0] hdf;       // Flipped horizontal position
    vcount_t    vrow;      // Row before scroll
    logic       in_score;
    logic       vflip;
    logic       hflip;
    logic [1:0] code_hi;
    logic [3:0] pal_bits;
    rom_word_t  pxl_data;  // Pixel shifter
    logic [3:0] cur_pal;
    logic       cur_hf;    // Shift direction for the current tile
    logic       blank_col;

    // Attribute decode
    assign vflip    = attr[ATTR_VFLIP];
    assign hflip    = attr[ATTR_HFLIP];
    assign code_hi  = attr[ATTR_CODE_LSB +: 2];
    assign pal_bits = attr[ATTR_PAL_LSB +: 4];

    // Mirror the scan position in flip mode
    assign hdf  = flip ? (~hdump[7:0]) - 8'd7 : hdump[7:0];
    assign vrow = vdump ^ {8{flip}};

    // Score columns do not scroll
    assign in_score = flip ? (hdf < SCORE_COLS) : (hdump < SCORE_COLS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vpos <= '0;
            vscr <= '0;
        end else begin
            if (scr_we) vpos <= scr_din;
            if (in_score) begin
                vscr <= vrow;
            end else begin
                vscr <= vrow + vpos + 8'd1; // +1 keeps the grid straight at boot
            end
        end
    end

    // Tile map address is 32x32 tiles
    assign vid_addr = {vscr[7:3], hdf[7:3]};

    // Unpacked ROM layout to pixel order
    // Each nibble gathers one bit from four planes
    function automatic rom_word_t unpack_word(input rom_word_t w);
        rom_word_t r;
        int        n;
        int        base;
        int        k;
        r = '0;
        for (n = 0; n < 8; n++) begin
            base = (n / 4) * 16; // Upper half of the word for pixels 4..7
            k    = n % 4;
            r[n*4 +: 4] = {w[base+8+k], w[base+12+k], w[base+k], w[base+4+k]};
        end
        return r;
    endfunction

    // ROM address at column start
    always_ff @(posedge clk) begin
        if (pxl_cen && hdf[2:0] == 3'd0) begin
            rom_addr <= {code_hi, code, vscr[2:0] ^ {3{vflip}}};
        end
    end

    // Load at the middle of the column, shift otherwise
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (hdf[2:0] == 3'd4) begin
                pxl_data <= unpack_word(rom_data);
                cur_hf   <= hflip ^ flip;
                cur_pal  <= pal_bits;
            end else if (cur_hf) begin
                pxl_data <= pxl_data >> 4;  // Low nibble first
            end else begin
                pxl_data <= pxl_data << 4;  // High nibble first
            end
        end
    end

    // First columns are not shown in flip mode
    assign blank_col = flip && (hdump < FLIP_BLANK_COLS);

    assign pal_addr = blank_col ? pal_addr_t'(0) :
                      {cur_pal, cur_hf ? pxl_data[3:0] : pxl_data[31:28]};

endmodule

//--- design/video_ram.sv
// 1 KB dual-port tile map RAM, both ports on clk
// Contents are undefined until the CPU writes them

`timescale 1ns/1ps

module video_ram
    import scroll_pkg::*;
(
    input  logic       clk,
    // CPU port
    input  vram_addr_t cpu_addr,
    input  byte_t      cpu_din,
    input  logic       cpu_we,
    output byte_t      cpu_q,
    // Video port, read only
    input  vram_addr_t vid_addr,
    output byte_t      vid_q
);

    byte_t mem [0:1023];

    // CPU side is write-first
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
            cpu_q         <= cpu_din; // New data shows at once
        end else begin
            cpu_q <= mem[cpu_addr];
        end
    end

    // Video fetch, one clk latency
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

//--- design/video_timing.sv
// Pixel enable plus H/V counters for a 384x264 raster
// Line count needs 9 bits; vdump carries only its low byte
// Blanking outputs are active low and purely decoded from the counters

`timescale 1ns/1ps

module video_timing
    import scroll_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    output logic    pxl_cen,
    output hcount_t hdump,
    output vcount_t vdump,
    output logic    lhbl,
    output logic    lvbl
);

    typedef logic [$clog2(CEN_DIV)-1:0] cen_cnt_t;

    cen_cnt_t   cen_cnt;
    logic [8:0] vcnt;     // Full line number
    logic       line_end;

    // Divider for the pixel enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            if (cen_cnt == cen_cnt_t'(CEN_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            pxl_cen <= (cen_cnt == cen_cnt_t'(CEN_DIV - 1)); // High one clk in CEN_DIV
        end
    end

    assign line_end = (hdump == hcount_t'(H_TOTAL - 1));

    // Pixel counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
        end else if (pxl_cen) begin
            hdump <= line_end ? hcount_t'(0) : hdump + 1'b1;
        end
    end

    // Line counter, steps at the last pixel of a line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vcnt <= '0;
        end else if (pxl_cen && line_end) begin
            if (vcnt == 9'(V_TOTAL - 1)) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end
    end

    assign vdump = vcnt[7:0];

    // Blanking
    assign lhbl = (hdump < H_ACTIVE);
    assign lvbl = (vcnt < V_ACTIVE);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the scroll layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=scroll_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module scroll_tb --Mdir "$OBJ" -o "$BIN" -f tile_scroll.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- tile_scroll.f
design/scroll_pkg.sv
design/video_ram.sv
design/palette_lut.sv
design/video_timing.sv
design/scroll_tile_engine.sv
design/scroll_layer.sv
verification/scroll_assertions.sv
verification/scroll_tb.sv

//--- verification/scroll_assertions.sv
// Concurrent checks on the tile engine, attached with bind
// Only meaningful after a clean reset

`timescale 1ns/1ps

module scroll_assertions
    import scroll_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input hcount_t   hdump,
    input vcount_t   vdump,
    input logic      flip,
    input vcount_t   vscr,
    input pal_addr_t pal_addr
);

    // Raster counters come out of reset clean
    property counters_known;
        @(posedge clk) disable iff (rst) !$isunknown({hdump, vdump});
    endproperty

    // Score columns take the raw line, registered one clk later
    property score_cols_fixed;
        @(posedge clk) disable iff (rst)
            (!flip && hdump < SCORE_COLS) |=> (vscr == $past(vdump));
    endproperty

    // Left edge forced to colour 0 when flipped
    property flip_cols_blank;
        @(posedge clk) disable iff (rst)
            (flip && hdump < FLIP_BLANK_COLS) |-> (pal_addr == '0);
    endproperty

    assert property (counters_known) else $error("hdump or vdump unknown after reset");
    assert property (score_cols_fixed) else $error("vscr differs from vdump in score columns");
    assert property (flip_cols_blank) else $error("pal_addr not zero in flipped blank columns");

endmodule

//--- verification/scroll_tb.sv
// Directed testbench for the scroll layer with a same-pixel random tile ROM
// Pixel checks match value order inside a tile, not the exact cycle

`timescale 1ns/1ps

module scroll_tb
    import scroll_pkg::*;
();

    localparam int unsigned     CLK_PERIOD  = 100;
    localparam longint unsigned FRAME_CLKS  = H_TOTAL * V_TOTAL * CEN_DIV;
    localparam longint unsigned SETUP_CLKS  = 8 * 1024 + 2000; // Bank fills, palette, reset
    localparam longint unsigned WATCHDOG_NS = (2 * FRAME_CLKS + SETUP_CLKS) * CLK_PERIOD;
    localparam int unsigned     CAPTURE_H   = 80; // Clear of score columns either way

    logic      clk;
    logic      rst;
    logic      flip;
    cpu_addr_t cpu_addr;
    byte_t     cpu_dout;
    logic      cpu_rnw;
    logic      vram_cs;
    logic      vscr_cs;
    byte_t     vram_dout;
    byte_t     vscr_dout;
    pal_addr_t prog_addr;
    pixel_t    prog_data;
    logic      prog_en;
    rom_addr_t rom_addr;
    rom_word_t rom_data;
    logic      pxl_cen;
    hcount_t   hdump;
    vcount_t   vdump;
    logic      lhbl;
    logic      lvbl;
    pixel_t    pxl;

    rom_word_t rom_mem [0:8191]; // Tile ROM model
    pixel_t    pal_shadow [0:255];
    byte_t     vpos;             // Last scroll value written
    int        errors;
    int        checks;

    scroll_layer i_scroll_layer (
        .clk(clk), .rst(rst), .flip(flip),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_rnw(cpu_rnw),
        .vram_cs(vram_cs), .vscr_cs(vscr_cs), .vram_dout(vram_dout), .vscr_dout(vscr_dout),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_en(prog_en),
        .rom_addr(rom_addr), .rom_data(rom_data),
        .pxl_cen(pxl_cen), .hdump(hdump), .vdump(vdump), .lhbl(lhbl), .lvbl(lvbl), .pxl(pxl)
    );

    bind scroll_tile_engine scroll_assertions i_scroll_assertions (
        .clk(clk), .rst(rst), .hdump(hdump), .vdump(vdump),
        .flip(flip), .vscr(vscr), .pal_addr(pal_addr)
    );

    assign rom_data = $isunknown(rom_addr) ? '0 : rom_mem[rom_addr]; // Same-pixel ROM

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t expected,
                                  input rom_addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Next falling edge inside a pixel-enable clk where hdump is stable
    task automatic wait_pixel(input hcount_t h);
        do @(negedge clk); while (!(pxl_cen && hdump == h));
    endtask

    task automatic next_pixel();
        do @(negedge clk); while (!pxl_cen);
    endtask

    // Expected scroll row from the raster position
    function automatic vcount_t scroll_row(input hcount_t h, input vcount_t v, input logic fl,
                                           input byte_t vp);
        logic [7:0] hf;
        logic       fixed;
        vcount_t    base;
        hf    = fl ? ~h[7:0] - 8'd7 : h[7:0];
        fixed = fl ? (hf < SCORE_COLS) : (h < SCORE_COLS);
        base  = v ^ {8{fl}};
        return fixed ? base : base + vp + 8'd1;
    endfunction

    // Kicker planes sit 4 bits apart inside each 16-bit half of the word
    function automatic pixel_t rom_pixel(input rom_word_t w, input int n);
        int     plane_off [4] = '{4, 0, 12, 8}; // Indexed by pixel bit
        pixel_t p;
        int     b;
        for (b = 0; b < 4; b++) begin
            p[b] = w[(n / 4) * 16 + plane_off[b] + n % 4];
        end
        return p;
    endfunction

    task automatic cpu_write(input cpu_addr_t addr, input byte_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_rnw  = 1'b0;
        vram_cs  = 1'b1;
        @(negedge clk);
        vram_cs = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic cpu_read(input cpu_addr_t addr, output byte_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_rnw  = 1'b1;
        vram_cs  = 1'b1;
        @(negedge clk);
        data    = vram_dout; // Registered read after one clk
        vram_cs = 1'b0;
    endtask

    task automatic fill_bank(input logic bank, input byte_t value);
        int a;
        for (a = 0; a < 1024; a++) begin
            @(negedge clk);
            cpu_addr = {bank, vram_addr_t'(a)};
            cpu_dout = value;
            cpu_rnw  = 1'b0;
            vram_cs  = 1'b1;
        end
        @(negedge clk);
        vram_cs = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic set_scroll(input byte_t value);
        @(negedge clk);
        cpu_dout = value;
        cpu_rnw  = 1'b0;
        vscr_cs  = 1'b1;
        @(negedge clk);
        vscr_cs = 1'b0;
        cpu_rnw = 1'b1;
        vpos    = value;
    endtask

    task automatic program_palette();
        int i;
        for (i = 0; i < 256; i++) begin
            @(negedge clk);
            pal_shadow[i] = pixel_t'($urandom);
            prog_addr     = pal_addr_t'(i);
            prog_data     = pal_shadow[i];
            prog_en       = 1'b1;
        end
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    task automatic vram_readback();
        byte_t      attr_shadow [0:1023];
        byte_t      code_shadow [0:1023];
        vram_addr_t used [$];
        vram_addr_t a;
        byte_t      got;
        int         i;
        for (i = 0; i < 16; i++) begin
            a              = vram_addr_t'($urandom);
            attr_shadow[a] = byte_t'($urandom);
            code_shadow[a] = byte_t'($urandom);
            cpu_write({1'b0, a}, attr_shadow[a]);
            cpu_write({1'b1, a}, code_shadow[a]); // Same address, other bank
            used.push_back(a);
        end
        for (i = 0; i < used.size(); i++) begin
            cpu_read({1'b0, used[i]}, got);
            check_byte("vram_attr", attr_shadow[used[i]], got);
            cpu_read({1'b1, used[i]}, got);
            check_byte("vram_code", code_shadow[used[i]], got);
        end
    endtask

    task automatic scroll_rule();
        int h_list [6] = '{3, 31, 32, 150, 255, 320};
        int pass;
        int i;
        for (pass = 0; pass < 2; pass++) begin
            set_scroll(pass == 0 ? 8'hff : byte_t'($urandom)); // Wrap case first
            for (i = 0; i < 6; i++) begin
                wait_pixel(hcount_t'(h_list[i]));
                check_byte("scroll_rule", scroll_row(hdump, vdump, 1'b0, vpos), vscr_dout);
            end
        end
    endtask

    task automatic fetch_check(input byte_t attr, input byte_t code, input hcount_t h);
        rom_addr_t expected;
        vcount_t   row;
        wait_pixel(h); // Fetch edge follows this falling edge
        row      = scroll_row(h, vdump, flip, vpos);
        expected = {attr[7:6], code, row[2:0] ^ {3{attr[ATTR_VFLIP]}}};
        @(negedge clk);
        check_rom_addr("rom_fetch", expected, rom_addr);
    endtask

    task automatic rom_fetch(input byte_t code);
        byte_t attr;
        int    pass;
        fill_bank(1'b1, code);
        for (pass = 0; pass < 2; pass++) begin
            attr = {2'($urandom), pass[0], 1'b0, 4'($urandom)}; // vflip on second pass
            fill_bank(1'b0, attr);
            fetch_check(attr, code, 8);   // Score column
            fetch_check(attr, code, 64);
            fetch_check(attr, code, 200);
        end
    endtask

    // Capture 16 pixels of identical tiles, find the tile phase, compare 8
    task automatic check_tile_pixels(input string name, input byte_t attr, input byte_t code);
        pixel_t    seen [0:15];
        pixel_t    expect_seq [0:7];
        rom_word_t word;
        vcount_t   row;
        logic      eff_hf;
        int        best;
        int        best_hits;
        int        hits;
        int        i;
        int        o;
        wait_pixel(0);
        wait_pixel(hcount_t'(CAPTURE_H));
        row    = scroll_row(hcount_t'(CAPTURE_H), vdump, flip, vpos);
        word   = rom_mem[{attr[7:6], code, row[2:0] ^ {3{attr[ATTR_VFLIP]}}}];
        eff_hf = attr[ATTR_HFLIP] ^ flip;
        for (i = 0; i < 8; i++) begin
            expect_seq[i] = pal_shadow[{attr[3:0], rom_pixel(word, eff_hf ? i : 7 - i)}];
        end
        seen[0] = pxl;
        for (i = 1; i < 16; i++) begin
            next_pixel();
            seen[i] = pxl;
        end
        best      = 0;
        best_hits = -1;
        for (o = 0; o < 8; o++) begin
            hits = 0;
            for (i = 0; i < 8; i++) begin
                if (seen[o + i] === expect_seq[i]) hits++;
            end
            if (hits > best_hits) begin
                best_hits = hits;
                best      = o;
            end
        end
        for (i = 0; i < 8; i++) begin
            check_pixel(name, expect_seq[i], seen[best + i]);
        end
    endtask

    task automatic pixel_path(input byte_t code);
        byte_t attr;
        program_palette();
        attr = {2'($urandom), 1'($urandom), 1'b0, 4'($urandom)};
        fill_bank(1'b0, attr);
        check_tile_pixels("pixel_order", attr, code);
        attr[ATTR_HFLIP] = 1'b1;
        fill_bank(1'b0, attr);
        check_tile_pixels("pixel_hflip", attr, code);
    endtask

    task automatic screen_flip(input byte_t code);
        byte_t attr;
        int    h;
        attr = {2'($urandom), 1'($urandom), 1'b0, 4'($urandom)};
        fill_bank(1'b0, attr);
        @(negedge clk);
        flip = 1'b1;
        wait_pixel(0);
        for (h = 1; h <= FLIP_BLANK_COLS; h++) begin
            wait_pixel(hcount_t'(h)); // pxl lags pal_addr by one pixel
            check_pixel("flip_blank", pal_shadow[0], pxl);
        end
        check_tile_pixels("flip_order", attr, code);
        @(negedge clk);
        flip = 1'b0;
    endtask

    // Blanking edges at the end of the visible line and of the visible frame
    task automatic blanking_levels();
        wait_pixel(hcount_t'(H_ACTIVE - 1));
        check_level("lhbl_active", 1'b1, lhbl);
        next_pixel();                 // First pixel past the visible width
        check_level("lhbl_blank", 1'b0, lhbl);
        wait_pixel(hcount_t'(H_TOTAL - 1));
        check_level("lhbl_blank", 1'b0, lhbl);
        wait_pixel(0);
        while (vdump != vcount_t'(V_ACTIVE - 1)) begin
            wait_pixel(0);
        end
        check_level("lhbl_active", 1'b1, lhbl);
        check_level("lvbl_active", 1'b1, lvbl);
        wait_pixel(0);                // First line past the visible height
        check_level("lvbl_blank", 1'b0, lvbl);
    endtask

    initial begin
        int    i;
        byte_t code;
        void'($urandom(50));
        errors    = 0;
        checks    = 0;
        vpos      = '0;
        rst       = 1'b1;
        flip      = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        vscr_cs   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        for (i = 0; i < 8192; i++) begin
            rom_mem[i] = $urandom;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst  = 1'b0;
        code = byte_t'($urandom);
        vram_readback();
        scroll_rule();
        rom_fetch(code);
        pixel_path(code);
        screen_flip(code);
        blanking_levels();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
